// File: rtl/aes_pkg.sv
package aes_pkg;

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;
    typedef logic [3:0]   adr_t;
    typedef logic [3:0]   round_t;

    ////////////////////////////////////////
    // Register map, word addresses
    ////////////////////////////////////////
    localparam adr_t KEY0 = 4'd0;
    localparam adr_t KEY1 = 4'd1;
    localparam adr_t KEY2 = 4'd2;
    localparam adr_t KEY3 = 4'd3;
    localparam adr_t PT0  = 4'd4;
    localparam adr_t PT1  = 4'd5;
    localparam adr_t PT2  = 4'd6;
    localparam adr_t PT3  = 4'd7;
    localparam adr_t CTRL = 4'd8;
    localparam adr_t CT0  = 4'd12;
    localparam adr_t CT1  = 4'd13;
    localparam adr_t CT2  = 4'd14;
    localparam adr_t CT3  = 4'd15;

    localparam round_t NUM_ROUNDS = 4'd10;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        adr_t  adr;
        word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic   go;
        block_t key;
        block_t block;
    } start_t;

    typedef struct packed {
        logic   valid;
        block_t block;
    } result_t;

    typedef enum logic [1:0] {
        IDLE,
        SUB,
        MIX
    } exec_state_t;

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t acc;
        byte_t x;
        acc = '0;
        x   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ x;
            end
            x = xtime(x);
        end
        return acc;
    endfunction

endpackage

// File: rtl/aes_sbox.sv
`timescale 1ns/1ps

module aes_sbox (
    input  logic           clk,
    input  aes_pkg::byte_t in,
    output aes_pkg::byte_t out
);

    aes_pkg::byte_t pw;
    aes_pkg::byte_t inv;
    aes_pkg::byte_t aff;

    // Inverse as in^254, the product of in^2, in^4 ... in^128
    // Zero stays zero on its own
    always_comb begin
        pw  = aes_pkg::gf_mul(in, in);
        inv = pw;
        for (int i = 0; i < 6; i++) begin
            pw  = aes_pkg::gf_mul(pw, pw);
            inv = aes_pkg::gf_mul(inv, pw);
        end
        // Affine map, sum of four left rotations plus 63
        aff = inv
            ^ {inv[6:0], inv[7]}
            ^ {inv[5:0], inv[7:6]}
            ^ {inv[4:0], inv[7:5]}
            ^ {inv[3:0], inv[7:4]}
            ^ 8'h63;
    end

    // Registered lookup, half of each two-cycle round
    always_ff @(posedge clk) begin
        out <= aff;
    end

endmodule

// File: rtl/aes_key_expand.sv
`timescale 1ns/1ps

module aes_key_expand (
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  logic            step,
    input  aes_pkg::block_t key_in,
    output aes_pkg::block_t round_key
);

    // key_q[3] is w0 of the current key
    aes_pkg::word_t [3:0] key_q;
    aes_pkg::word_t [3:0] next_key;
    aes_pkg::word_t       rot_word;
    aes_pkg::word_t       sub_word;
    aes_pkg::byte_t       sub_b [4];
    aes_pkg::byte_t       rcon_q;

    // RotWord of the last key word
    assign rot_word = {key_q[0][23:0], key_q[0][31:24]};

    for (genvar i = 0; i < 4; i++) begin : g_sbox
        aes_sbox u_sbox (
            .clk (clk),
            .in  (rot_word[8*i +: 8]),
            .out (sub_b[i])
        );
    end

    assign sub_word = {sub_b[3], sub_b[2], sub_b[1], sub_b[0]};

    // Next round key, valid in the MIX cycle once the S-boxes have registered
    assign next_key[3] = key_q[3] ^ sub_word ^ {rcon_q, 24'd0};
    assign next_key[2] = key_q[2] ^ next_key[3];
    assign next_key[1] = key_q[1] ^ next_key[2];
    assign next_key[0] = key_q[0] ^ next_key[1];
    assign round_key   = next_key;

    always_ff @(posedge clk) begin
        if (rst || load) begin
            rcon_q <= 8'h01;
        end else if (step) begin
            rcon_q <= aes_pkg::xtime(rcon_q);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            key_q <= key_in;
        end else if (step) begin
            key_q <= next_key;
        end
    end

endmodule

// File: rtl/aes_round_exec.sv
`timescale 1ns/1ps

module aes_round_exec (
    input  logic             clk,
    input  logic             rst,
    input  aes_pkg::start_t  start,
    output logic             busy,
    output aes_pkg::result_t res
);

    aes_pkg::exec_state_t fsm_q;
    aes_pkg::round_t      round_q;
    aes_pkg::block_t      state_q;
    aes_pkg::block_t      round_key;
    aes_pkg::block_t      next_state;
    aes_pkg::byte_t       sb [16];
    aes_pkg::byte_t       sr [16];
    logic                 valid_q;
    logic                 last;

    assign last = (round_q == aes_pkg::NUM_ROUNDS);
    assign busy = (fsm_q != aes_pkg::IDLE);

    // Byte i of the state is row i%4, column i/4, MSB first
    for (genvar i = 0; i < 16; i++) begin : g_sbox
        aes_sbox u_sbox (
            .clk (clk),
            .in  (state_q[127 - 8*i -: 8]),
            .out (sb[i])
        );
    end

    aes_key_expand u_key_expand (
        .clk       (clk),
        .rst       (rst),
        .load      (start.go),
        .step      (fsm_q == aes_pkg::MIX),
        .key_in    (start.key),
        .round_key (round_key)
    );

    ////////////////////////////////////////
    // ShiftRows, MixColumns, AddRoundKey
    ////////////////////////////////////////
    always_comb begin
        aes_pkg::byte_t col [4];
        aes_pkg::byte_t mix [4];
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                sr[4*c + r] = sb[4*((c + r) % 4) + r];
            end
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                col[r] = sr[4*c + r];
            end
            // 2a0 ^ 3a1 ^ a2 ^ a3, rotated per row
            for (int r = 0; r < 4; r++) begin
                mix[r] = aes_pkg::xtime(col[r]) ^ aes_pkg::xtime(col[(r + 1) % 4])
                       ^ col[(r + 1) % 4] ^ col[(r + 2) % 4] ^ col[(r + 3) % 4];
            end
            // Last round has no MixColumns
            for (int r = 0; r < 4; r++) begin
                next_state[127 - 8*(4*c + r) -: 8] = (last ? col[r] : mix[r])
                                                   ^ round_key[127 - 8*(4*c + r) -: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fsm_q   <= aes_pkg::IDLE;
            round_q <= '0;
            valid_q <= 1'b0;
        end else if (start.go) begin
            fsm_q   <= aes_pkg::SUB;
            round_q <= 4'd1;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (fsm_q)
                aes_pkg::SUB: fsm_q <= aes_pkg::MIX;
                aes_pkg::MIX: begin
                    if (last) begin
                        fsm_q   <= aes_pkg::IDLE;
                        valid_q <= 1'b1;
                    end else begin
                        fsm_q   <= aes_pkg::SUB;
                        round_q <= round_q + 4'd1;
                    end
                end
                default: fsm_q <= aes_pkg::IDLE;
            endcase
        end
    end

    // Initial AddRoundKey on go, one round per MIX cycle after that
    always_ff @(posedge clk) begin
        if (start.go) begin
            state_q <= start.block ^ start.key;
        end else if (fsm_q == aes_pkg::MIX) begin
            state_q <= next_state;
        end
    end

    assign res.valid = valid_q;
    assign res.block = state_q;

endmodule

// File: rtl/aes_result.sv
`timescale 1ns/1ps

module aes_result (
    input  logic             clk,
    input  logic             rst,
    input  logic             go,
    input  aes_pkg::result_t res,
    output logic             done,
    output aes_pkg::block_t  ct
);

    // Sticky until the next block starts
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (res.valid) begin
            done <= 1'b1;
        end else if (go) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ct <= '0;
        end else if (res.valid) begin
            ct <= res.block;
        end
    end

endmodule

// File: rtl/aes_wb_decode.sv
`timescale 1ns/1ps

module aes_wb_decode (
    input  logic             clk,
    input  logic             rst,
    input  aes_pkg::wb_req_t req,
    input  logic             busy,
    input  logic             done,
    input  aes_pkg::block_t  ct,
    output aes_pkg::word_t   rdata,
    output logic             ack,
    output aes_pkg::start_t  start
);

    // Element 3 holds word 0, so each array packs straight into a block
    aes_pkg::word_t [3:0] key_q;
    aes_pkg::word_t [3:0] pt_q;
    aes_pkg::word_t [3:0] ct_w;
    logic [1:0]           widx;
    logic                 access;
    logic                 go_q;

    assign ct_w   = ct;
    assign widx   = 2'd3 - req.adr[1:0];
    assign access = req.cyc && req.stb && !ack;

    ////////////////////////////////////////
    // Ack, register writes, start pulse
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= 1'b0;
            go_q  <= 1'b0;
            key_q <= '0;
            pt_q  <= '0;
        end else begin
            ack  <= access;
            // Start while busy is dropped here
            go_q <= access && req.we && (req.adr == aes_pkg::CTRL) && req.dat[0] && !busy;
            if (access && req.we) begin
                case (req.adr)
                    aes_pkg::KEY0, aes_pkg::KEY1, aes_pkg::KEY2, aes_pkg::KEY3:
                        key_q[widx] <= req.dat;
                    aes_pkg::PT0, aes_pkg::PT1, aes_pkg::PT2, aes_pkg::PT3:
                        pt_q[widx] <= req.dat;
                    default: ;
                endcase
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (access) begin
            case (req.adr)
                aes_pkg::KEY0, aes_pkg::KEY1, aes_pkg::KEY2, aes_pkg::KEY3:
                    rdata <= key_q[widx];
                aes_pkg::PT0, aes_pkg::PT1, aes_pkg::PT2, aes_pkg::PT3:
                    rdata <= pt_q[widx];
                aes_pkg::CTRL:
                    rdata <= {30'd0, done, busy};
                aes_pkg::CT0, aes_pkg::CT1, aes_pkg::CT2, aes_pkg::CT3:
                    rdata <= ct_w[widx];
                default:
                    rdata <= '0;
            endcase
        end
    end

    assign start.go    = go_q;
    assign start.key   = key_q;
    assign start.block = pt_q;

endmodule

// File: rtl/aes_wb_top.sv
`timescale 1ns/1ps

module aes_wb_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           cyc,
    input  logic           stb,
    input  logic           we,
    input  aes_pkg::adr_t  adr,
    input  aes_pkg::word_t wdata,
    output aes_pkg::word_t rdata,
    output logic           ack
);

    aes_pkg::wb_req_t req;
    aes_pkg::start_t  start;
    aes_pkg::result_t res;
    aes_pkg::block_t  ct;
    logic             busy;
    logic             done;

    assign req = '{cyc: cyc, stb: stb, we: we, adr: adr, dat: wdata};

    aes_wb_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .ct    (ct),
        .rdata (rdata),
        .ack   (ack),
        .start (start)
    );

    aes_round_exec u_exec (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .res   (res)
    );

    aes_result u_result (
        .clk  (clk),
        .rst  (rst),
        .go   (start.go),
        .res  (res),
        .done (done),
        .ct   (ct)
    );

endmodule

// File: test/aes_chk.sv
`timescale 1ns/1ps

module aes_chk (
    input logic             clk,
    input logic             rst,
    input logic             cyc,
    input logic             stb,
    input logic             ack,
    input logic             busy,
    input logic             done,
    input aes_pkg::start_t  start,
    input aes_pkg::result_t res
);

    // Read by the testbench at the end of each test
    int fail_count = 0;

    ////////////////////////////////////////
    // Wishbone handshake
    ////////////////////////////////////////
    ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else begin
            $error("ack stayed high for more than one cycle");
            fail_count++;
        end

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(cyc && stb && !ack))
        else begin
            $error("ack raised without a cyc and stb request");
            fail_count++;
        end

    ////////////////////////////////////////
    // Engine timing and status
    ////////////////////////////////////////
    status_excl: assert property (@(posedge clk) disable iff (rst) !(busy && done))
        else begin
            $error("busy and done high together");
            fail_count++;
        end

    go_to_valid: assert property (@(posedge clk) disable iff (rst)
        start.go |-> ##21 res.valid)
        else begin
            $error("no result 21 cycles after go");
            fail_count++;
        end

    // Result only where a go was seen 21 cycles earlier
    valid_from_go: assert property (@(posedge clk) disable iff (rst)
        res.valid |-> $past(start.go, 21))
        else begin
            $error("result without a go 21 cycles earlier");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !ack && !busy && !done)
        else begin
            $error("ack, busy or done high during reset");
            fail_count++;
        end

endmodule

bind aes_wb_top aes_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .busy  (busy),
    .done  (done),
    .start (start),
    .res   (res)
);

// File: test/aes_tb.sv
`timescale 1ns/1ps

module aes_tb;

    localparam int ACK_TIMEOUT  = 20;
    localparam int DONE_TIMEOUT = 50;

    // FIPS-197 vectors
    localparam aes_pkg::block_t KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::block_t PT_A  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::block_t CT_A  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam aes_pkg::block_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aes_pkg::block_t PT_B  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam aes_pkg::block_t CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;

    logic           clk;
    logic           rst;
    logic           cyc;
    logic           stb;
    logic           we;
    aes_pkg::adr_t  adr;
    aes_pkg::word_t wdata;
    aes_pkg::word_t rdata;
    logic           ack;

    int errors;
    int mark;
    int tests;
    int failed;
    int acks;
    int accesses;
    int results;

    aes_wb_top UUT (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack)
    );

    always #2 clk = ~clk;

    // Ack cycles and result pulses seen on the bus
    always @(posedge clk) begin
        if (ack) begin
            acks++;
        end
        if (UUT.res.valid) begin
            results++;
        end
    end

    function automatic int total_errors();
        return errors + UUT.u_chk.fail_count;
    endfunction

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic check_word(input string what, input aes_pkg::word_t got,
                              input aes_pkg::word_t exp);
        assert (got == exp) else begin
            $display("MISMATCH at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////
    task automatic wait_ack(input aes_pkg::adr_t a);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        while (!ack && n < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!ack) begin
            abort_run($sformatf("No ack for an access to address %0d", a));
        end
    endtask

    task automatic wb_write(input aes_pkg::adr_t a, input aes_pkg::word_t d);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        wdata = d;
        wait_ack(a);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        accesses++;
    endtask

    task automatic wb_read(input aes_pkg::adr_t a, output aes_pkg::word_t d);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        wait_ack(a);
        d   = rdata;
        cyc = 1'b0;
        stb = 1'b0;
        accesses++;
    endtask

    task automatic load_block(input aes_pkg::block_t key, input aes_pkg::block_t pt);
        for (int i = 0; i < 4; i++) begin
            wb_write(aes_pkg::KEY0 + 4'(i), key[127 - 32*i -: 32]);
            wb_write(aes_pkg::PT0 + 4'(i), pt[127 - 32*i -: 32]);
        end
    endtask

    // Poll CTRL until done
    task automatic wait_done();
        aes_pkg::word_t st;
        int n;
        st = '0;
        n  = 0;
        while (!st[1] && n < DONE_TIMEOUT) begin
            wb_read(aes_pkg::CTRL, st);
            n++;
        end
        if (!st[1]) begin
            abort_run("Done never set after a start");
        end
    endtask

    task automatic check_ct(input aes_pkg::block_t exp);
        aes_pkg::word_t w;
        for (int i = 0; i < 4; i++) begin
            wb_read(aes_pkg::CT0 + 4'(i), w);
            check_word($sformatf("CT%0d", i), w, exp[127 - 32*i -: 32]);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (total_errors() == mark) begin
            $display("Test %0d (%s) ok", tests, name);
        end else begin
            failed++;
            $display("Test %0d (%s) failed", tests, name);
        end
        mark = total_errors();
    endtask

    initial begin
        aes_pkg::word_t w;
        aes_pkg::word_t key_w [4];
        aes_pkg::word_t pt_w [4];
        int first;
        clk      = 1'b0;
        rst      = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        wdata    = '0;
        errors   = 0;
        mark     = 0;
        tests    = 0;
        failed   = 0;
        acks     = 0;
        accesses = 0;
        results  = 0;
        void'($urandom(32'h0045_be0b));
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset values, one ack per access
        wb_read(aes_pkg::CTRL, w);
        check_word("CTRL", w, 32'h0);
        check_ct('0);
        @(posedge clk);
        #1;
        assert (acks == accesses) else begin
            $display("MISMATCH at %0t ns: %0d acks for %0d accesses", $time, acks, accesses);
            errors++;
        end
        finish_test("reset values");

        for (int i = 0; i < 4; i++) begin
            key_w[i] = $urandom;
            pt_w[i]  = $urandom;
            wb_write(aes_pkg::KEY0 + 4'(i), key_w[i]);
            wb_write(aes_pkg::PT0 + 4'(i), pt_w[i]);
        end
        for (int i = 0; i < 4; i++) begin
            wb_read(aes_pkg::KEY0 + 4'(i), w);
            check_word($sformatf("KEY%0d", i), w, key_w[i]);
            wb_read(aes_pkg::PT0 + 4'(i), w);
            check_word($sformatf("PT%0d", i), w, pt_w[i]);
        end
        for (int a = 9; a < 12; a++) begin
            wb_write(4'(a), $urandom);
            wb_read(4'(a), w);
            check_word($sformatf("address %0d", a), w, 32'h0);
        end
        finish_test("register readback");

        load_block(KEY_A, PT_A);
        wb_write(aes_pkg::CTRL, 32'h1);
        wait_done();
        check_ct(CT_A);
        wb_read(aes_pkg::CTRL, w);
        check_word("CTRL", w, 32'h2);
        finish_test("first vector");

        // done must drop as soon as the new block starts
        load_block(KEY_B, PT_B);
        wb_write(aes_pkg::CTRL, 32'h1);
        wb_read(aes_pkg::CTRL, w);
        check_word("CTRL after start", w, 32'h1);
        wait_done();
        check_ct(CT_B);
        finish_test("second vector");

        load_block(KEY_B, PT_B);
        first = results;
        wb_write(aes_pkg::CTRL, 32'h1);
        wb_write(aes_pkg::CTRL, 32'h1);
        load_block({$urandom, $urandom, $urandom, $urandom},
                   {$urandom, $urandom, $urandom, $urandom});
        wait_done();
        check_ct(CT_B);
        assert (results - first == 1) else begin
            $display("MISMATCH at %0t ns: %0d results for one block", $time, results - first);
            errors++;
        end
        finish_test("writes while busy");

        load_block(KEY_A, PT_A);
        wb_write(aes_pkg::CTRL, 32'h1);
        wait_done();
        check_ct(CT_A);
        finish_test("restart");

        $display("Tests run %0d, failed %0d, errors %0d", tests, failed, total_errors());
        if (total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/aes_pkg.sv
rtl/aes_sbox.sv
rtl/aes_key_expand.sv
rtl/aes_round_exec.sv
rtl/aes_result.sv
rtl/aes_wb_decode.sv
rtl/aes_wb_top.sv
test/aes_chk.sv
test/aes_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the AES Wishbone testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ"
verilator --binary --timing --assert --top-module aes_tb -f verilog.f \
    --Mdir "$OBJ" -o aes_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

# Keep running after assertion errors so the testbench can report them
"$OBJ/aes_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    exit 0
fi
exit 1
